//--- source/rx_pkg.sv
// rx_pkg: shared link widths, framing bytes, crc-32 constants and buffer depth for the rx path
package rx_pkg;

    // data lines on the link, one nibble per clock edge
    localparam int unsigned nibble_width = 4;

    // bits in one decoded byte
    localparam int unsigned byte_width = 8;

    // frame length counter width, frames up to 2047 bytes
    localparam int unsigned len_width = 11;

    // start-of-frame delimiter, closes the preamble
    localparam logic [7:0] sfd_byte = 8'hd5;

    // preamble filler byte
    localparam logic [7:0] preamble_byte = 8'h55;

    // crc-32 as used by the ethernet fcs
    // reflected form, lsb shifted first
    localparam logic [31:0] crc_poly = 32'hedb88320;

    // crc register start value
    localparam logic [31:0] crc_init = 32'hffffffff;

    // register value left once data and a correct fcs have passed through
    // the fcs is sent inverted, so the register does not end at zero
    localparam logic [31:0] crc_residue = 32'hdebb20e3;

    // default elastic buffer depth in entries
    // must stay a power of two
    localparam int unsigned default_fifo_depth = 16;

endpackage

//--- source/ddr_capture.sv
// ddr_capture: double data rate input register, both edge samples presented on the rising edge
module ddr_capture #(
    // bits captured per edge
    parameter int width = 1
) (
    input  logic             clk,
    input  logic [width-1:0] d,
    output logic [width-1:0] q1,
    output logic [width-1:0] q2
);

    // falling edge sample, waits here half a cycle
    logic [width-1:0] d_fall;

    // rising edge sample goes straight to q1
    always_ff @(posedge clk) begin
        q1 <= d;
    end

    // falling edge sample
    // taken at the low phase, before the next rising edge
    always_ff @(negedge clk) begin
        d_fall <= d;
    end

    // re-time the falling sample onto the rising edge
    // q1 and q2 then update on the same edge
    // q2 holds the sample from the falling edge just before
    always_ff @(posedge clk) begin
        q2 <= d_fall;
    end

endmodule

//--- source/ssio_ddr_in.sv
// ssio_ddr_in: source synchronous ddr input, forwards the receive clock and captures on both edges
module ssio_ddr_in #(
    // total lines captured, data plus control
    parameter int width = 1
) (
    // forwarded clock from the link partner
    input  logic             input_clk,

    // ddr input lines
    input  logic [width-1:0] input_d,

    // clock for the logic behind this block
    output logic             output_clk,

    // rising edge sample
    output logic [width-1:0] output_q1,
    // falling edge sample, aligned to the rising edge
    output logic [width-1:0] output_q2
);

    // clock seen by the capture registers
    logic clk_io;
    // clock seen by the downstream logic
    logic clk_int;

    // generic form, no clock buffers
    // both branches come straight from the receive clock
    assign clk_io  = input_clk;
    assign clk_int = input_clk;

    // hand the logic clock to the rest of the design
    assign output_clk = clk_int;

    // edge pair capture on the io clock
    ddr_capture #(
        .width (width)
    ) u_data_capture (
        .clk (clk_io),
        .d   (input_d),
        .q1  (output_q1),
        .q2  (output_q2)
    );

endmodule

//--- source/rgmii_rx_decoder.sv
// rgmii_rx_decoder: joins nibble pairs into bytes, strips preamble and sfd, marks last byte and errors
module rgmii_rx_decoder (
    input  logic                          clk,
    input  logic                          reset,
    // bit 4 is the control line, bits 3:0 the data lines
    input  logic [rx_pkg::nibble_width:0] q_rise,
    input  logic [rx_pkg::nibble_width:0] q_fall,
    output logic                          byte_valid,
    output logic [rx_pkg::byte_width-1:0] byte_data,
    output logic                          byte_last,
    output logic                          byte_err
);

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_data
    } state_t;

    state_t state;

    // rising sample from the previous cycle
    // its partner falling sample arrives one cycle later on q_fall
    logic [rx_pkg::nibble_width:0] rise_q;

    // current byte, built from the delayed rising and current falling samples
    logic                          cur_dv;
    logic                          cur_er;
    logic [rx_pkg::byte_width-1:0] cur_data;
    logic                          cur_sfd;

    // one byte hold so the final byte can still be tagged as last
    logic                          hold_valid;
    logic [rx_pkg::byte_width-1:0] hold_data;
    logic                          hold_err;

    // low nibble comes from the rising edge
    assign cur_data = {q_fall[rx_pkg::nibble_width-1:0], rise_q[rx_pkg::nibble_width-1:0]};
    // control high at the rising edge marks frame data
    assign cur_dv = rise_q[rx_pkg::nibble_width];
    // control samples that disagree flag a receive error
    assign cur_er = rise_q[rx_pkg::nibble_width] ^ q_fall[rx_pkg::nibble_width];
    assign cur_sfd = (cur_data == rx_pkg::sfd_byte);

    always_ff @(posedge clk) begin
        if (reset) begin
            rise_q <= '0;
        end else begin
            rise_q <= q_rise;
        end
    end

    // framing fsm plus hold register
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            hold_valid <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            // strobe, clear unless a byte goes out this cycle
            byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    hold_valid <= 1'b0;
                    if (cur_dv) begin
                        // zero length preamble goes straight to data
                        state <= cur_sfd ? st_data : st_preamble;
                    end
                end
                st_preamble: begin
                    // frame gone before the delimiter, nothing emitted
                    if (!cur_dv) begin
                        state <= st_idle;
                    end else if (cur_sfd) begin
                        state <= st_data;
                    end
                end
                st_data: begin
                    // release the previous byte
                    // last when the control line has dropped
                    if (hold_valid) begin
                        byte_valid <= 1'b1;
                    end
                    if (cur_dv) begin
                        hold_valid <= 1'b1;
                    end else begin
                        hold_valid <= 1'b0;
                        state      <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (state == st_data) begin
            byte_data <= hold_data;
            byte_err  <= hold_err;
            byte_last <= !cur_dv;
        end
        hold_data <= cur_data;
        hold_err  <= cur_er;
    end

endmodule

//--- source/rx_byte_fifo.sv
// rx_byte_fifo: elastic byte buffer with last and error flags, drops writes when full
module rx_byte_fifo #(
    // entries, power of two of at least 4
    parameter int fifo_depth = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wr,
    input  logic [rx_pkg::byte_width-1:0] wr_data,
    input  logic                          wr_last,
    input  logic                          wr_err,
    input  logic                          rd,
    output logic [rx_pkg::byte_width-1:0] rd_data,
    output logic                          rd_last,
    output logic                          rd_err,
    output logic                          empty,
    output logic                          overflow
);

    localparam int addr_width = $clog2(fifo_depth);
    // entry layout, err on top, then last, then the byte
    localparam int entry_width = rx_pkg::byte_width + 2;

    logic [entry_width-1:0] mem [fifo_depth];

    // one extra bit tells full from empty
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] rd_ptr;

    logic full;
    logic do_wr;
    logic do_rd;

    logic [entry_width-1:0] head;

    assign empty = (wr_ptr == rd_ptr);
    // same slot, opposite lap
    assign full  = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                   (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // head entry shown before the read strobe
    assign head    = mem[rd_ptr[addr_width-1:0]];
    assign rd_data = head[rx_pkg::byte_width-1:0];
    assign rd_last = head[rx_pkg::byte_width];
    assign rd_err  = head[rx_pkg::byte_width+1];

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[addr_width-1:0]] <= {wr_err, wr_last, wr_data};
        end
    end

    // pointers and sticky overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // byte lost, stays flagged until reset
            if (wr && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

//--- source/rx_frame_checker.sv
// rx_frame_checker: drains the byte buffer, counts bytes, checks the fcs and reports each frame
module rx_frame_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          empty,
    input  logic [rx_pkg::byte_width-1:0] rd_data,
    input  logic                          rd_last,
    input  logic                          rd_err,
    output logic                          rd,
    output logic                          frame_valid,
    output logic [rx_pkg::len_width-1:0]  frame_len,
    output logic                          frame_good,
    output logic                          frame_err
);

    // count holds bytes before the current one
    // length is count + 1 minus the four fcs bytes
    localparam logic [rx_pkg::len_width-1:0] fcs_adjust = 3;

    // running crc over the frame so far
    logic [31:0] crc;
    logic [31:0] crc_next;

    // bytes read so far in this frame
    logic [rx_pkg::len_width-1:0] byte_cnt;

    // any error flag seen so far
    logic err_seen;
    logic err_any;

    // one byte of the reflected crc-32, lsb first
    function automatic logic [31:0] crc_update(
        input logic [31:0]                   crc_in,
        input logic [rx_pkg::byte_width-1:0] data
    );
        logic [31:0] c;
        c = crc_in ^ {{(32 - rx_pkg::byte_width){1'b0}}, data};
        for (int i = 0; i < rx_pkg::byte_width; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ rx_pkg::crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // take a byte whenever one is waiting
    // the decoder never writes faster than one per cycle
    assign rd = !empty;

    assign crc_next = crc_update(crc, rd_data);
    assign err_any  = err_seen | rd_err;

    // per frame accumulation
    always_ff @(posedge clk) begin
        if (reset) begin
            crc         <= rx_pkg::crc_init;
            byte_cnt    <= '0;
            err_seen    <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (rd) begin
                if (rd_last) begin
                    // report, then start over for the next frame
                    frame_valid <= 1'b1;
                    crc         <= rx_pkg::crc_init;
                    byte_cnt    <= '0;
                    err_seen    <= 1'b0;
                end else begin
                    crc      <= crc_next;
                    byte_cnt <= byte_cnt + 1'b1;
                    err_seen <= err_any;
                end
            end
        end
    end

    // report fields, valid with frame_valid
    always_ff @(posedge clk) begin
        if (rd && rd_last) begin
            // payload length, fcs excluded
            frame_len  <= byte_cnt - fcs_adjust;
            // residue match and a clean frame
            frame_good <= (crc_next == rx_pkg::crc_residue) && !err_any;
            frame_err  <= err_any;
        end
    end

endmodule

//--- source/rgmii_rx_top.sv
// rgmii_rx_top: rgmii receive front end, ddr capture to decoder to byte buffer to frame checker
module rgmii_rx_top #(
    // byte buffer depth, power of two
    parameter int fifo_depth = rx_pkg::default_fifo_depth
) (
    input  logic                            rx_clk,
    input  logic [rx_pkg::nibble_width-1:0] rgmii_rxd,
    input  logic                            rgmii_rx_ctl,
    input  logic                            reset,
    output logic                            frame_valid,
    output logic [rx_pkg::len_width-1:0]    frame_len,
    output logic                            frame_good,
    output logic                            frame_err,
    output logic                            overflow
);

    // design clock, the receive clock passed through
    logic clk;

    // edge pair, control line on top
    logic [rx_pkg::nibble_width:0] q_rise;
    logic [rx_pkg::nibble_width:0] q_fall;

    // decoder to buffer
    logic                          byte_valid;
    logic [rx_pkg::byte_width-1:0] byte_data;
    logic                          byte_last;
    logic                          byte_err;

    // buffer to checker
    logic                          rd;
    logic [rx_pkg::byte_width-1:0] rd_data;
    logic                          rd_last;
    logic                          rd_err;
    logic                          empty;

    ssio_ddr_in #(
        .width (rx_pkg::nibble_width + 1)
    ) u_ssio (
        .input_clk  (rx_clk),
        .input_d    ({rgmii_rx_ctl, rgmii_rxd}),
        .output_clk (clk),
        .output_q1  (q_rise),
        .output_q2  (q_fall)
    );

    rgmii_rx_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .q_rise     (q_rise),
        .q_fall     (q_fall),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_last  (byte_last),
        .byte_err   (byte_err)
    );

    rx_byte_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .wr       (byte_valid),
        .wr_data  (byte_data),
        .wr_last  (byte_last),
        .wr_err   (byte_err),
        .rd       (rd),
        .rd_data  (rd_data),
        .rd_last  (rd_last),
        .rd_err   (rd_err),
        .empty    (empty),
        .overflow (overflow)
    );

    rx_frame_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .empty       (empty),
        .rd_data     (rd_data),
        .rd_last     (rd_last),
        .rd_err      (rd_err),
        .rd          (rd),
        .frame_valid (frame_valid),
        .frame_len   (frame_len),
        .frame_good  (frame_good),
        .frame_err   (frame_err)
    );

endmodule

//--- tests/rgmii_rx_tb.sv
// rgmii_rx_tb: replays frames from the pattern file on the rgmii ddr pins and checks each frame report
module rgmii_rx_tb;

    localparam int clk_period = 100;
    localparam int reset_cycles = 5;
    // words in the pattern memory
    localparam int pat_words = 512;
    localparam int max_frames = 64;
    // count, error index, gap, report flag, len, good, err
    localparam int hdr_words = 7;
    // cycles after the last report in which no further report may show up
    localparam int settle_cycles = 10;

    logic                            rx_clk;
    logic [rx_pkg::nibble_width-1:0] rgmii_rxd;
    logic                            rgmii_rx_ctl;
    logic                            reset;
    logic                            frame_valid;
    logic [rx_pkg::len_width-1:0]    frame_len;
    logic                            frame_good;
    logic                            frame_err;
    logic                            overflow;

    logic [15:0] pat_mem [pat_words];

    // idle cycles after each frame, fixed before the run starts
    int gap_cycles [max_frames];
    int num_frames;
    int cycle_limit;
    int cycle_count;
    logic [31:0] rng_state;

    // expected reports, oldest first
    logic [rx_pkg::len_width-1:0] exp_len_q [$];
    logic                         exp_good_q [$];
    logic                         exp_err_q [$];

    rgmii_rx_top #(
        .fifo_depth (rx_pkg::default_fifo_depth)
    ) u_dut (
        .rx_clk       (rx_clk),
        .rgmii_rxd    (rgmii_rxd),
        .rgmii_rx_ctl (rgmii_rx_ctl),
        .reset        (reset),
        .frame_valid  (frame_valid),
        .frame_len    (frame_len),
        .frame_good   (frame_good),
        .frame_err    (frame_err),
        .overflow     (overflow)
    );

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_len(
        input string                        name,
        input logic [rx_pkg::len_width-1:0] got,
        input logic [rx_pkg::len_width-1:0] exp
    );
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // one byte over one clock, low nibble ahead of the rising edge
    // control is dv on the rising half and dv xor err on the falling half
    task automatic drive_byte(input logic [rx_pkg::byte_width-1:0] data, input logic err);
        @(negedge rx_clk);
        rgmii_rxd    <= data[rx_pkg::nibble_width-1:0];
        rgmii_rx_ctl <= 1'b1;
        @(posedge rx_clk);
        rgmii_rxd    <= data[rx_pkg::byte_width-1:rx_pkg::nibble_width];
        rgmii_rx_ctl <= !err;
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge rx_clk);
            rgmii_rxd    <= '0;
            rgmii_rx_ctl <= 1'b0;
            @(posedge rx_clk);
            rgmii_rxd    <= '0;
            rgmii_rx_ctl <= 1'b0;
        end
    endtask

    // walk the records, draw the gaps and size the timeout
    task automatic plan_run();
        int p;
        int total;
        int gap;
        p = 0;
        total = 0;
        num_frames = 0;
        rng_state = 32'h655308a4;
        while (pat_mem[p] !== 16'h0000 && num_frames < max_frames) begin
            if ($isunknown(pat_mem[p])) begin
                $display("pattern file is missing or a record is cut short");
                abort_run();
            end
            // gap word 0 picks a random gap of 2 to 9 cycles
            if (pat_mem[p+2] == 16'h0000) begin
                rng_state = xorshift32(rng_state);
                gap = 2 + int'(rng_state[2:0]);
            end else begin
                gap = int'(pat_mem[p+2]);
            end
            gap_cycles[num_frames] = gap;
            total = total + int'(pat_mem[p]) + gap;
            num_frames++;
            p = p + hdr_words + int'(pat_mem[p]);
        end
        cycle_limit = 2 * total + 100;
    endtask

    initial begin
        rx_clk = 1'b0;
        forever #(clk_period / 2) rx_clk = ~rx_clk;
    end

    initial begin : main_seq
        int p;
        int count;
        logic [15:0] err_idx;
        rgmii_rxd = '0;
        rgmii_rx_ctl = 1'b0;
        reset = 1'b1;
        $readmemh("tests/rx_patterns.txt", pat_mem);
        plan_run();
        repeat (reset_cycles) @(posedge rx_clk);
        reset <= 1'b0;
        p = 0;
        for (int f = 0; f < num_frames; f++) begin
            count = int'(pat_mem[p]);
            // ffff never matches a byte index
            err_idx = pat_mem[p+1];
            if (pat_mem[p+3] != 16'h0000) begin
                exp_len_q.push_back(pat_mem[p+4][rx_pkg::len_width-1:0]);
                exp_good_q.push_back(pat_mem[p+5][0]);
                exp_err_q.push_back(pat_mem[p+6][0]);
            end
            for (int i = 0; i < count; i++) begin
                drive_byte(pat_mem[p+hdr_words+i][rx_pkg::byte_width-1:0], err_idx == i);
            end
            drive_idle(gap_cycles[f]);
            p = p + hdr_words + count;
        end
        // outstanding reports, bounded by the watchdog
        while (exp_len_q.size() != 0) begin
            @(posedge rx_clk);
        end
        repeat (settle_cycles) @(posedge rx_clk);
        $display("Simulation finished: PASS");
        $finish;
    end

    // outputs sampled mid cycle, away from the rising edge
    initial begin : report_monitor
        logic [rx_pkg::len_width-1:0] e_len;
        logic                         e_good;
        logic                         e_err;
        forever begin
            @(negedge rx_clk);
            if (!reset) begin
                if (overflow !== 1'b0) begin
                    $display("byte buffer overflow flag went high");
                    abort_run();
                end
                if (frame_valid === 1'b1) begin
                    if (exp_len_q.size() == 0) begin
                        $display("frame report arrived with no frame pending");
                        abort_run();
                    end
                    e_len  = exp_len_q.pop_front();
                    e_good = exp_good_q.pop_front();
                    e_err  = exp_err_q.pop_front();
                    check_len("frame_len", frame_len, e_len);
                    check_flag("frame_good", frame_good, e_good);
                    check_flag("frame_err", frame_err, e_err);
                end else if (frame_valid !== 1'b0) begin
                    $display("frame_valid is unknown after reset");
                    abort_run();
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        forever begin
            @(posedge rx_clk);
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("run did not finish within %0d cycles", cycle_limit);
                abort_run();
            end
        end
    end

endmodule

//--- tests/rx_patterns.txt
// header: byte count, error byte index (ffff none), gap (0 random), report expected, len, good, err
// then the bytes as sent on the link, preamble and sfd first, fcs last; a count of 0 ends the file
// good frame, payload 123456789
0015 ffff 0000 0001 0009 0001 0000
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 cb
// same payload, top fcs byte altered
0015 ffff 0000 0001 0009 0000 0000
55 55 55 55 55 55 55 d5 31 32 33 34 35 36 37 38 39 26 39 f4 ca
// payload abc, control mismatch on byte b
000f 0009 0000 0001 0003 0000 0001
55 55 55 55 55 55 55 d5 61 62 63 c2 41 24 35
// abc with full preamble, minimal gap
000f ffff 0001 0001 0003 0001 0000
55 55 55 55 55 55 55 d5 61 62 63 c2 41 24 35
// abc with a one byte preamble
0009 ffff 0001 0001 0003 0001 0000
55 d5 61 62 63 c2 41 24 35
// abc with no preamble at all
0008 ffff 0001 0001 0003 0001 0000
d5 61 62 63 c2 41 24 35
// empty payload, fcs only
000c ffff 0000 0001 0000 0001 0000
55 55 55 55 55 55 55 d5 00 00 00 00
// preamble burst with no delimiter, no report
0004 ffff 0000 0000 0000 0000 0000
55 55 55 55
// single byte payload a
000d ffff 0001 0001 0001 0001 0000
55 55 55 55 55 55 55 d5 61 43 be b7 e8
// payload hello world
0017 ffff 0000 0001 000b 0001 0000
55 55 55 55 55 55 55 d5 68 65 6c 6c 6f 20 77 6f 72 6c 64
85 11 4a 0d
// end of records
0000

//--- compile.f
source/rx_pkg.sv
source/ddr_capture.sv
source/ssio_ddr_in.sv
source/rgmii_rx_decoder.sv
source/rx_byte_fifo.sv
source/rx_frame_checker.sv
source/rgmii_rx_top.sv
tests/rgmii_rx_tb.sv
